//--- tb/mem_test_vectors.txt
# kind offset data resp (hex). W write, R read and compare, F fault addr mask
# P wait until PASS+FAIL reaches offset field, E elapsed check (offset 1 = seconds nonzero)
W 04 00005a3c 0
R 04 00005a3c 0
W 00 00000001 0
E 0
P 2
E 1
P 4
R 08 00000004 0
R 0c 00000000 0
R 14 00000000 0
E 1
W 00 00000002 0
F 15 00000002
W 00 00000001 0
P 4
R 08 00000002 0
R 0c 00000002 0
R 14 80000015 0
E 1
W 00 00000002 0
R 08 00000000 0
R 0c 00000000 0
R 14 00000000 0
R 10 00000000 0
F 15 00000000
W 20 00000000 2
R 20 00000000 2
R 04 00005a3c 0

//--- project.f
source/mem_test_pkg.sv
source/mem_test_engine.sv
source/elapsed_timer.sv
source/status_regs.sv
source/mem_test_top.sv
tb/mem_test_checker.sv
tb/mem_test_tb.sv

//--- Makefile
TOP := mem_test_tb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- tb/mem_test_tb.sv
`default_nettype none

module mem_test_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_test_pkg::*;

    localparam int    ADDR_W        = 6;
    localparam int    DATA_W        = 16;
    localparam int    TICKS_PER_SEC = 4;
    localparam int    PASS_CYCLES   = 4 * (1 << ADDR_W);  // Worst case for one memory pass
    localparam string VEC_FILE      = "tb/mem_test_vectors.txt";

    logic              CLK_50M;
    logic              rst_n;
    logic [7:0]        awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [7:0]        araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    mem_req_t          mem_req;
    logic              mem_ready;
    logic [DATA_W-1:0] mem_rdata;

    logic [DATA_W-1:0] mem_words [0:(1 << ADDR_W)-1];
    logic [ADDR_W-1:0] fault_addr;
    logic [DATA_W-1:0] fault_mask;     // Stuck-at-one bits on fault_addr
    logic [31:0]       prev_elapsed;
    int                check_errors;
    int                cycle_count;
    int                cycle_limit;

    mem_test_top #(
        .ADDR_W        (ADDR_W),
        .DATA_W        (DATA_W),
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) DUT (
        .CLK_50M (CLK_50M), .rst_n (rst_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .mem_req (mem_req), .mem_ready (mem_ready), .mem_rdata (mem_rdata)
    );

    initial begin
        CLK_50M = 1'b0;
        forever #10 CLK_50M = ~CLK_50M;
    end

    // Memory model, one cycle read latency
    initial begin : memory_model
        logic              take;
        logic              wr;
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        mem_ready = 1'b0;
        mem_rdata = '0;
        void'($urandom(32'h9ba3_c0c1));
        forever begin
            @(posedge CLK_50M);
            take = mem_req.valid && mem_ready;
            wr   = mem_req.we;
            a    = mem_req.addr;
            d    = mem_req.wdata;
            #2;
            if (take && wr) mem_words[a] = d;
            if (take && !wr) mem_rdata = mem_words[a] | ((a == fault_addr) ? fault_mask : '0);
            mem_ready = ($urandom % 4) != 0;   // About three cycles in four
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge CLK_50M);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a handshake or a pass never completed", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic string reg_name(input logic [7:0] a);
        case (a)
            REG_CTRL:       return "CTRL";
            REG_SEED:       return "SEED";
            REG_PASS:       return "PASS";
            REG_FAIL:       return "FAIL_COUNT";
            REG_ELAPSED:    return "ELAPSED";
            REG_FIRST_FAIL: return "FIRST_FAIL";
            default:        return "UNMAPPED";
        endcase
    endfunction

    function automatic bit is_data(input string line);
        return line.len() > 1 && line[0] != "#";   // Skip comments and blank lines
    endfunction

    task automatic report_mismatch(input string name, input string expect_text,
                                   input logic [31:0] actual);
        $display("FAIL t=%0t %s expected %s actual %h", $time, name, expect_text, actual);
        check_errors++;
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic aw_hit;
        logic w_hit;
        @(posedge CLK_50M);
        #2;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            @(posedge CLK_50M);
            aw_hit = awready && awvalid;
            w_hit  = wready && wvalid;
            #2;
            if (aw_hit) awvalid = 1'b0;
            if (w_hit)  wvalid  = 1'b0;
        end
        do @(posedge CLK_50M); while (!bvalid);
        #2 bready = 1'b1;   // Response waits one cycle under back-pressure
        @(posedge CLK_50M);
        resp = bresp;
        #2 bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge CLK_50M);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge CLK_50M); while (!arready);
        #2 arvalid = 1'b0;
        do @(posedge CLK_50M); while (!rvalid);
        #2 rready = 1'b1;   // Read data held one cycle before rready
        @(posedge CLK_50M);
        data = rdata;
        resp = rresp;
        #2 rready = 1'b0;
    endtask

    // Poll until PASS plus FAIL reaches the target
    task automatic wait_passes(input int target);
        logic [31:0] p;
        logic [31:0] f;
        logic [1:0]  resp;
        do begin
            axi_read(REG_PASS, p, resp);
            axi_read(REG_FAIL, f, resp);
        end while (p + f < target);
    endtask

    task automatic check_elapsed(input logic need_secs);
        logic [31:0] v;
        logic [1:0]  resp;
        int          i;
        axi_read(REG_ELAPSED, v, resp);
        assert (v >= prev_elapsed)
            else report_mismatch("ELAPSED", $sformatf("at least %h", prev_elapsed), v);
        for (i = 0; i < 4; i++) begin
            assert (v[16 + i*4 +: 4] <= 4'd9)
                else report_mismatch($sformatf("ELAPSED minutes digit %0d", i), "at most 9",
                                     32'(v[16 + i*4 +: 4]));
        end
        if (need_secs) begin
            assert (v[15:0] != 16'd0) else report_mismatch("ELAPSED seconds", "nonzero", v);
        end
        prev_elapsed = v;
    endtask

    task automatic run_vector(input logic [7:0] op, input logic [31:0] f1,
                              input logic [31:0] f2, input logic [31:0] f3);
        logic [31:0] got;
        logic [1:0]  resp;
        case (op)
            "W": begin
                axi_write(f1[7:0], f2, resp);
                if (f1[7:0] == REG_CTRL) prev_elapsed = '0;  // Timer restarts from zero
                assert (resp == f3[1:0])
                    else report_mismatch({reg_name(f1[7:0]), " bresp"}, $sformatf("%h", f3[1:0]),
                                         32'(resp));
            end
            "R": begin
                axi_read(f1[7:0], got, resp);
                assert (got == f2)
                    else report_mismatch(reg_name(f1[7:0]), $sformatf("%h", f2), got);
                assert (resp == f3[1:0])
                    else report_mismatch({reg_name(f1[7:0]), " rresp"}, $sformatf("%h", f3[1:0]),
                                         32'(resp));
            end
            "F": begin
                fault_addr = f1[ADDR_W-1:0];
                fault_mask = f2[DATA_W-1:0];
            end
            "P": wait_passes(f1);
            "E": check_elapsed(f1[0]);
            default: begin
                $display("Unknown line kind %c in the vector file", op);
                check_errors++;
            end
        endcase
    endtask

    // Sum the waited pass counts to size the watchdog
    task automatic scan_vectors(output int waits, output int lines);
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] f1;
        waits = 0;
        lines = 0;
        fd    = $fopen(VEC_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (is_data(line)) begin
                    void'($sscanf(line, "%c %h", op, f1));
                    lines++;
                    if (op == "P") waits += f1;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : stimulus
        int          waits;
        int          lines;
        int          fd;
        int          asserts;
        string       line;
        logic [7:0]  op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        fault_addr   = '0;
        fault_mask   = '0;
        prev_elapsed = '0;
        check_errors = 0;
        scan_vectors(waits, lines);
        cycle_limit = 8 + waits * PASS_CYCLES + lines * 40 + 100;
        repeat (8) @(posedge CLK_50M);
        #2 rst_n = 1'b1;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            check_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (is_data(line)) begin
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    void'($sscanf(line, "%c %h %h %h", op, f1, f2, f3));
                    run_vector(op, f1, f2, f3);
                end
            end
            $fclose(fd);
        end

        asserts = DUT.u_checker.assert_errors;
        $display("Errors: %0d register checks, %0d bound assertions", check_errors, asserts);
        if (check_errors == 0 && asserts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mem_test_checker.sv
`default_nettype none

module mem_test_checker (
    input wire                         CLK_50M,
    input wire                         rst_n,
    input wire mem_test_pkg::mem_req_t mem_req,
    input wire                         mem_ready,
    input wire                         bvalid,
    input wire                         bready,
    input wire  [1:0]                  bresp,
    input wire                         rvalid,
    input wire                         rready,
    input wire  [31:0]                 rdata,
    input wire  [1:0]                  rresp,
    input wire                         clear,
    input wire  [31:0]                 pass_cnt,
    input wire  [31:0]                 fail_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;   // Picked up by the testbench summary

    // Waiting request keeps every field
    req_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        mem_req.valid && !mem_ready |=> mem_req.valid && $stable(mem_req))
    else begin
        assert_errors++;
        $error("memory request changed before it was accepted");
    end

    b_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        assert_errors++;
        $error("write response dropped or changed before bready");
    end

    r_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        assert_errors++;
        $error("read data dropped or changed before rready");
    end

    // Only clear may lower the counts
    counts_rise: assert property (@(posedge CLK_50M) disable iff (!rst_n)
        !clear |=> pass_cnt >= $past(pass_cnt) && fail_cnt >= $past(fail_cnt))
    else begin
        assert_errors++;
        $error("pass or fail count went down without a clear");
    end

endmodule

bind mem_test_top mem_test_checker u_checker (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp),
    .clear     (clear),
    .pass_cnt  (u_status.pass_cnt),
    .fail_cnt  (u_status.fail_cnt)
);

`default_nettype wire

//--- source/mem_test_top.sv
`default_nettype none

module mem_test_top #(
    parameter int ADDR_W        = mem_test_pkg::ADDR_W_DEF,
    parameter int DATA_W        = mem_test_pkg::DATA_W_DEF,
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  wire                    CLK_50M,
    input  wire                    rst_n,
    // AXI4-Lite slave
    input  wire  [7:0]             awaddr,
    input  wire                    awvalid,
    output logic                   awready,
    input  wire  [31:0]            wdata,
    input  wire  [3:0]             wstrb,
    input  wire                    wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire                    bready,
    input  wire  [7:0]             araddr,
    input  wire                    arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire                    rready,
    // Memory port
    output mem_test_pkg::mem_req_t mem_req,
    input  wire                    mem_ready,
    input  wire  [DATA_W-1:0]      mem_rdata
);
    import mem_test_pkg::*;

    logic              run;
    logic              clear;
    logic [DATA_W-1:0] seed;
    result_t           result;      // Pass summary from the engine
    logic [15:0]       secs;
    logic [15:0]       mins_bcd;

    mem_test_engine #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_engine (
        .CLK_50M   (CLK_50M),
        .rst_n     (rst_n),
        .run       (run),
        .clear     (clear),
        .seed      (seed),
        .mem_req   (mem_req),
        .result    (result),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    elapsed_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_timer (
        .CLK_50M  (CLK_50M),
        .rst_n    (rst_n),
        .run      (run),
        .clear    (clear),
        .secs     (secs),
        .mins_bcd (mins_bcd)
    );

    status_regs #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_status (
        .CLK_50M  (CLK_50M),
        .rst_n    (rst_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .run      (run),
        .clear    (clear),
        .seed     (seed),
        .result   (result),
        .secs     (secs),
        .mins_bcd (mins_bcd)
    );

endmodule

`default_nettype wire

//--- source/status_regs.sv
`default_nettype none

module status_regs #(
    parameter int ADDR_W = mem_test_pkg::ADDR_W_DEF,
    parameter int DATA_W = mem_test_pkg::DATA_W_DEF
) (
    input  wire                   CLK_50M,
    input  wire                   rst_n,
    input  wire  [7:0]            awaddr,
    input  wire                   awvalid,
    output logic                  awready,
    input  wire  [31:0]           wdata,
    input  wire  [3:0]            wstrb,
    input  wire                   wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  wire                   bready,
    input  wire  [7:0]            araddr,
    input  wire                   arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  wire                   rready,
    output logic                  run,
    output logic                  clear,
    output logic [DATA_W-1:0]     seed,
    input  wire mem_test_pkg::result_t result,
    input  wire  [15:0]           secs,
    input  wire  [15:0]           mins_bcd
);
    import mem_test_pkg::*;

    logic              aw_have;     // Address captured, waiting for data
    logic              w_have;
    logic [7:0]        aw_addr;
    logic [31:0]       w_data;
    logic [3:0]        w_strb;
    logic              aw_fire;
    logic              w_fire;
    logic              commit;
    logic [7:0]        wr_addr;
    logic [31:0]       wr_data;
    logic [3:0]        wr_strb;
    logic [31:0]       pass_cnt;
    logic [31:0]       fail_cnt;
    logic              first_valid;
    logic [ADDR_W-1:0] first_addr;
    logic [31:0]       rd_word;
    logic              rd_err;

    // Byte-lane merge for partial writes
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] strb);
        logic [31:0] r;
        int          i;
        r = old;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) r[i*8 +: 8] = nw[i*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [7:0] word_addr(input logic [7:0] a);
        return {a[7:2], 2'b00};
    endfunction

    assign aw_fire = awready && awvalid;
    assign w_fire  = wready && wvalid;
    assign wr_addr = aw_have ? aw_addr : awaddr;   // Either channel may come first
    assign wr_data = w_have ? w_data : wdata;
    assign wr_strb = w_have ? w_strb : wstrb;
    assign commit  = (aw_have || aw_fire) && (w_have || w_fire) && !bvalid;

    always_ff @(posedge CLK_50M or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            aw_addr <= '0;
            w_data  <= '0;
            w_strb  <= '0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            run     <= 1'b0;
            clear   <= 1'b0;
            seed    <= '0;
        end else begin
            clear <= 1'b0;   // One-cycle pulse

            if (aw_fire) begin
                awready <= 1'b0;
                aw_addr <= awaddr;
            end else if (!aw_have && !bvalid) begin
                awready <= 1'b1;
            end
            if (w_fire) begin
                wready <= 1'b0;
                w_data <= wdata;
                w_strb <= wstrb;
            end else if (!w_have && !bvalid) begin
                wready <= 1'b1;
            end

            if (commit)       aw_have <= 1'b0;
            else if (aw_fire) aw_have <= 1'b1;
            if (commit)       w_have  <= 1'b0;
            else if (w_fire)  w_have  <= 1'b1;

            if (commit) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                case (word_addr(wr_addr))
                    REG_CTRL: begin
                        if (wr_strb[0]) begin
                            run   <= wr_data[CTRL_RUN_BIT];
                            clear <= wr_data[CTRL_CLEAR_BIT];
                        end
                    end
                    REG_SEED:       seed <= DATA_W'(merge(32'(seed), wr_data, wr_strb));
                    REG_PASS, REG_FAIL, REG_ELAPSED, REG_FIRST_FAIL: ;  // Read only
                    default:        bresp <= RESP_SLVERR;
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Pass and fail accounting
    always_ff @(posedge CLK_50M or negedge rst_n) begin
        if (!rst_n) begin
            pass_cnt    <= '0;
            fail_cnt    <= '0;
            first_valid <= 1'b0;
            first_addr  <= '0;
        end else if (clear) begin
            pass_cnt    <= '0;
            fail_cnt    <= '0;
            first_valid <= 1'b0;
            first_addr  <= '0;
        end else if (result.done) begin
            if (result.clean) pass_cnt <= pass_cnt + 32'd1;
            else              fail_cnt <= fail_cnt + 32'd1;
            if (result.first_seen && !first_valid) begin
                first_valid <= 1'b1;            // Held until the next clear
                first_addr  <= ADDR_W'(result.first_addr);
            end
        end
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (word_addr(araddr))
            REG_CTRL:       rd_word = 32'(run);
            REG_SEED:       rd_word = 32'(seed);
            REG_PASS:       rd_word = pass_cnt;
            REG_FAIL:       rd_word = fail_cnt;
            REG_ELAPSED:    rd_word = {mins_bcd, secs};
            REG_FIRST_FAIL: rd_word = {first_valid, 31'(first_addr)};
            default:        rd_err  = 1'b1;  // Unmapped reads return zero
        endcase
    end

    always_ff @(posedge CLK_50M or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= RESP_OKAY;
        end else if (arready && arvalid) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= rd_word;
            rresp   <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/elapsed_timer.sv
`default_nettype none

module elapsed_timer #(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  wire         CLK_50M,
    input  wire         rst_n,
    input  wire         run,
    input  wire         clear,
    output logic [15:0] secs,      // Binary seconds
    output logic [15:0] mins_bcd   // Four BCD digits
);

    localparam int TICK_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SEC - 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [5:0]        sec_in_min;  // 0 to 59
    logic              sec_tick;

    // Add one to a four-digit BCD value, wraps at 9999
    function automatic logic [15:0] bcd_inc(input logic [15:0] v);
        logic [15:0] r;
        logic        carry;
        int          i;
        r     = v;
        carry = 1'b1;
        for (i = 0; i < 4; i++) begin
            if (carry) begin
                if (r[i*4 +: 4] >= 4'd9) begin
                    r[i*4 +: 4] = 4'd0;
                end else begin
                    r[i*4 +: 4] = r[i*4 +: 4] + 4'd1;
                    carry       = 1'b0;
                end
            end
        end
        return r;
    endfunction

    assign sec_tick = (tick_cnt == TICK_LAST);

    always_ff @(posedge CLK_50M or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt   <= '0;
            sec_in_min <= '0;
            secs       <= '0;
            mins_bcd   <= '0;
        end else if (!run || clear) begin
            tick_cnt   <= '0;   // Stopped test reads as zero
            sec_in_min <= '0;
            secs       <= '0;
            mins_bcd   <= '0;
        end else if (sec_tick) begin
            tick_cnt <= '0;
            secs     <= secs + 16'd1;
            if (sec_in_min == 6'd59) begin
                sec_in_min <= '0;
                mins_bcd   <= bcd_inc(mins_bcd);
            end else begin
                sec_in_min <= sec_in_min + 6'd1;
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_test_engine.sv
`default_nettype none

module mem_test_engine #(
    parameter int ADDR_W = mem_test_pkg::ADDR_W_DEF,
    parameter int DATA_W = mem_test_pkg::DATA_W_DEF
) (
    input  wire                    CLK_50M,
    input  wire                    rst_n,
    input  wire                    run,
    input  wire                    clear,
    input  wire  [DATA_W-1:0]      seed,
    output mem_test_pkg::mem_req_t mem_req,
    output mem_test_pkg::result_t  result,
    input  wire                    mem_ready,
    input  wire  [DATA_W-1:0]      mem_rdata
);
    import mem_test_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_DRAIN
    } state_t;

    localparam logic [ADDR_W-1:0] LAST_ADDR = '1;

    state_t            state;
    logic              parity;       // Odd passes use the inverted pattern
    logic              req_valid;
    logic              req_we;
    logic [ADDR_W-1:0] req_addr;     // Doubles as the address counter
    logic [DATA_W-1:0] req_wdata;
    logic              tag_valid;    // Read data due this cycle
    logic [ADDR_W-1:0] tag_addr;
    logic [DATA_W-1:0] tag_exp;
    logic              bad_seen;
    logic [ADDR_W-1:0] bad_addr;
    logic              accept;
    logic              abort;
    logic              miss;

    // Seed XOR address, inverted on odd passes
    function automatic logic [DATA_W-1:0] pattern(input logic [ADDR_W-1:0] a,
                                                  input logic odd);
        logic [DATA_W-1:0] p;
        p = seed ^ DATA_W'(a);
        return odd ? ~p : p;
    endfunction

    assign accept = req_valid && mem_ready;
    assign abort  = clear || !run;
    assign miss   = tag_valid && (mem_rdata != tag_exp);

    assign mem_req = '{valid: req_valid,
                       we:    req_we,
                       addr:  ADDR_W_DEF'(req_addr),
                       wdata: DATA_W_DEF'(req_wdata)};

    always_ff @(posedge CLK_50M or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            parity    <= 1'b0;
            req_valid <= 1'b0;
            req_we    <= 1'b0;
            req_addr  <= '0;
            req_wdata <= '0;
            tag_valid <= 1'b0;
            tag_addr  <= '0;
            tag_exp   <= '0;
            bad_seen  <= 1'b0;
            bad_addr  <= '0;
            result    <= '0;
        end else begin
            result.done <= 1'b0;
            tag_valid   <= 1'b0;

            // Compare the word returned for last cycle's read
            if (miss && !bad_seen) begin
                bad_seen <= 1'b1;
                bad_addr <= tag_addr;
            end

            if (abort) begin
                state <= ST_IDLE;              // Pass dropped, nothing counted
                if (accept) req_valid <= 1'b0; // Pending request stays until taken
                if (clear)  parity    <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (accept) begin
                            req_valid <= 1'b0;
                        end else if (!req_valid) begin
                            state     <= ST_WRITE;
                            req_valid <= 1'b1;
                            req_we    <= 1'b1;
                            req_addr  <= '0;
                            req_wdata <= pattern('0, parity);
                            bad_seen  <= 1'b0;
                        end
                    end
                    ST_WRITE: begin
                        if (accept) begin
                            if (req_addr == LAST_ADDR) begin
                                state    <= ST_READ;   // Reads go out back to back
                                req_we   <= 1'b0;
                                req_addr <= '0;
                            end else begin
                                req_addr  <= req_addr + 1'b1;
                                req_wdata <= pattern(req_addr + 1'b1, parity);
                            end
                        end
                    end
                    ST_READ: begin
                        if (accept) begin
                            tag_valid <= 1'b1;
                            tag_addr  <= req_addr;
                            tag_exp   <= pattern(req_addr, parity);
                            if (req_addr == LAST_ADDR) begin
                                state     <= ST_DRAIN;
                                req_valid <= 1'b0;
                            end else begin
                                req_addr <= req_addr + 1'b1;
                            end
                        end
                    end
                    ST_DRAIN: begin
                        // Last word arrives now, fold it into the summary
                        result.done       <= 1'b1;
                        result.clean      <= !(bad_seen || miss);
                        result.first_seen <= bad_seen || miss;
                        result.first_addr <= ADDR_W_DEF'(bad_seen ? bad_addr : tag_addr);
                        parity            <= ~parity;
                        state             <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mem_test_pkg.sv
`default_nettype none

package mem_test_pkg;

    // Default geometry of the memory under test
    localparam int ADDR_W_DEF = 6;
    localparam int DATA_W_DEF = 16;

    // One request on the memory port
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [ADDR_W_DEF-1:0] addr;
        logic [DATA_W_DEF-1:0] wdata;
    } mem_req_t;

    // Pass summary, sent once at the end of each pass
    typedef struct packed {
        logic                  done;        // One-cycle strobe
        logic                  clean;       // Every word matched
        logic [ADDR_W_DEF-1:0] first_addr;
        logic                  first_seen;  // first_addr holds a mismatch
    } result_t;

    // Register map, byte offsets of 32-bit words
    localparam logic [7:0] REG_CTRL       = 8'h00;
    localparam logic [7:0] REG_SEED       = 8'h04;
    localparam logic [7:0] REG_PASS       = 8'h08;
    localparam logic [7:0] REG_FAIL       = 8'h0C;
    localparam logic [7:0] REG_ELAPSED    = 8'h10;
    localparam logic [7:0] REG_FIRST_FAIL = 8'h14;

    // CTRL fields
    localparam int CTRL_RUN_BIT   = 0;
    localparam int CTRL_CLEAR_BIT = 1;   // Self-clearing

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
